// File: logic/mem_pkg.sv
// Scratch memory and request constants
package mem_pkg;

        // -------------------------------------------------------------------------
        // Memory geometry
        // -------------------------------------------------------------------------
        localparam int MEM_ADDR_W = 4;
        localparam int MEM_DATA_W = 8;
        // Sixteen words
        localparam int MEM_DEPTH  = 1 << MEM_ADDR_W;

        // Opcode on top, then address, then data
        localparam int REQ_W      = 1 + MEM_ADDR_W + MEM_DATA_W;

        // Channel count and channel number width
        localparam int N_CH       = 2;
        localparam int CH_W       = (N_CH > 1) ? $clog2(N_CH) : 1;

        // Request opcode
        typedef enum logic {
                op_write = 1'b0,
                op_read  = 1'b1
        } req_op_t;

endpackage : mem_pkg

// File: logic/fifo_pkg.sv
// Request FIFO constants
package fifo_pkg;

        // -------------------------------------------------------------------------
        // Channel FIFO geometry
        // -------------------------------------------------------------------------

        // Entries held per channel
        localparam int FIFO_DEPTH = 4;

        // One packed request per entry
        localparam int FIFO_DATA_W = mem_pkg::REQ_W;

        // Address bits plus the wrap bit
        localparam int FIFO_CNT_W = $clog2(FIFO_DEPTH) + 1;

endpackage : fifo_pkg

// File: logic/fifo_control.sv
// FIFO flag and count logic
`timescale 1ns/1ps

module fifo_control (
        input  logic                            axi_aclk,
        input  logic                            axi_aresetn,
        input  logic [fifo_pkg::FIFO_CNT_W-1:0] i_wr_ptr,
        input  logic [fifo_pkg::FIFO_CNT_W-1:0] i_rd_ptr,
        output logic [fifo_pkg::FIFO_CNT_W-1:0] o_count,
        output logic                            o_full,
        output logic                            o_empty
);

        localparam int CW = fifo_pkg::FIFO_CNT_W;
        localparam int AW = CW - 1;
        // Depth at count width for the wrapped case
        localparam logic [CW-1:0] DEPTH_C = CW'(fifo_pkg::FIFO_DEPTH);

        // Pointer fields
        logic          w_wr_wrap;
        logic          w_rd_wrap;
        logic [AW-1:0] w_wr_addr;
        logic [AW-1:0] w_rd_addr;

        assign w_wr_wrap = i_wr_ptr[AW];
        assign w_rd_wrap = i_rd_ptr[AW];
        assign w_wr_addr = i_wr_ptr[AW-1:0];
        assign w_rd_addr = i_rd_ptr[AW-1:0];

        // -------------------------------------------------------------------------
        // Flags
        // -------------------------------------------------------------------------

        // Same slot, one lap apart
        assign o_full  = (w_wr_addr == w_rd_addr) && (w_wr_wrap != w_rd_wrap);
        assign o_empty = (i_wr_ptr == i_rd_ptr);

        // Occupancy
        always_comb begin
                if (w_wr_wrap == w_rd_wrap) begin
                        // Same lap, plain difference
                        o_count = {1'b0, w_wr_addr} - {1'b0, w_rd_addr};
                end else begin
                        // Writer one lap ahead
                        o_count = DEPTH_C + {1'b0, w_wr_addr} - {1'b0, w_rd_addr};
                end
        end

endmodule : fifo_control

// File: logic/gaxi_fifo_sync.sv
// Synchronous ready/valid FIFO
`timescale 1ns/1ps

module gaxi_fifo_sync #(
        parameter int DATA_WIDTH = fifo_pkg::FIFO_DATA_W,
        parameter int DEPTH      = fifo_pkg::FIFO_DEPTH
) (
        input  logic                                axi_aclk,
        input  logic                                axi_aresetn,
        // Write side
        input  logic                                i_wr_valid,
        output logic                                o_wr_ready,
        input  logic [DATA_WIDTH-1:0]               i_wr_data,
        // Read side
        input  logic                                i_rd_ready,
        output logic                                o_rd_valid,
        output logic [DATA_WIDTH-1:0]               o_rd_data,
        // Occupancy
        output logic [((DEPTH > 1) ? $clog2(DEPTH) : 1):0] o_count
);

        // Slot address bits, pointer adds a wrap bit
        localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
        localparam int CW = AW + 1;
        localparam logic [AW-1:0] LAST_SLOT = AW'(DEPTH - 1);

        // -------------------------------------------------------------------------
        // Local signals
        // -------------------------------------------------------------------------
        logic [CW-1:0]         r_wr_ptr;
        logic [CW-1:0]         r_rd_ptr;
        logic [CW-1:0]         w_wr_ptr_next;
        logic [CW-1:0]         w_rd_ptr_next;
        logic                  w_full;
        logic                  w_empty;
        logic                  w_write;
        logic                  w_read;
        logic [DATA_WIDTH-1:0] r_mem [DEPTH];

        // Next pointer
        // Last slot jumps to slot 0 and flips the wrap bit
        function automatic logic [CW-1:0] ptr_inc(input logic [CW-1:0] ptr);
                logic [CW-1:0] nxt;
                if (ptr[AW-1:0] == LAST_SLOT) begin
                        nxt = {~ptr[AW], {AW{1'b0}}};
                end else begin
                        nxt = ptr + CW'(1);
                end
                return nxt;
        endfunction

        // -------------------------------------------------------------------------
        // Handshakes
        // -------------------------------------------------------------------------
        assign o_wr_ready = !w_full;
        assign o_rd_valid = !w_empty;

        assign w_write = i_wr_valid && o_wr_ready;
        assign w_read  = i_rd_ready && o_rd_valid;

        assign w_wr_ptr_next = ptr_inc(r_wr_ptr);
        assign w_rd_ptr_next = ptr_inc(r_rd_ptr);

        // Pointer registers
        always_ff @(posedge axi_aclk) begin
                if (!axi_aresetn) begin
                        r_wr_ptr <= '0;
                        r_rd_ptr <= '0;
                end else begin
                        if (w_write) begin
                                r_wr_ptr <= w_wr_ptr_next;
                        end
                        if (w_read) begin
                                r_rd_ptr <= w_rd_ptr_next;
                        end
                end
        end

        // -------------------------------------------------------------------------
        // Flags and count
        // -------------------------------------------------------------------------
        fifo_control u_fifo_control (
                .axi_aclk    (axi_aclk),
                .axi_aresetn (axi_aresetn),
                .i_wr_ptr    (r_wr_ptr),
                .i_rd_ptr    (r_rd_ptr),
                .o_count     (o_count),
                .o_full      (w_full),
                .o_empty     (w_empty)
        );

        // -------------------------------------------------------------------------
        // Storage
        // -------------------------------------------------------------------------

        // Write on accepted push
        always_ff @(posedge axi_aclk) begin
                if (w_write) begin
                        r_mem[r_wr_ptr[AW-1:0]] <= i_wr_data;
                end
        end

        // Head shown without a register stage
        assign o_rd_data = r_mem[r_rd_ptr[AW-1:0]];

endmodule : gaxi_fifo_sync

// File: logic/rr_arbiter.sv
// Round-robin channel arbiter
`timescale 1ns/1ps

module rr_arbiter (
        input  logic                        axi_aclk,
        input  logic                        axi_aresetn,
        input  logic [mem_pkg::N_CH-1:0]    i_valid,
        output logic [mem_pkg::N_CH-1:0]    o_grant,
        output logic                        o_req_strobe,
        output logic [mem_pkg::CH_W-1:0]    o_grant_ch
);

        localparam int NC = mem_pkg::N_CH;
        localparam int CW = mem_pkg::CH_W;

        // Channel granted most recently
        logic [CW-1:0] r_last_ch;

        // -------------------------------------------------------------------------
        // Rotating priority
        // -------------------------------------------------------------------------

        // Search starts one past the last winner
        always_comb begin : rr_pick
                int   idx;
                logic found;
                o_grant    = '0;
                o_grant_ch = '0;
                found      = 1'b0;
                for (int i = 1; i <= NC; i++) begin
                        idx = (int'(r_last_ch) + i) % NC;
                        if (!found && i_valid[idx]) begin
                                found        = 1'b1;
                                o_grant[idx] = 1'b1;
                                o_grant_ch   = CW'(idx);
                        end
                end
        end

        // Memory never stalls
        assign o_req_strobe = |o_grant;

        // Last winner, reset to the top channel so channel 0 wins first
        always_ff @(posedge axi_aclk) begin
                if (!axi_aresetn) begin
                        r_last_ch <= CW'(NC - 1);
                end else if (o_req_strobe) begin
                        r_last_ch <= o_grant_ch;
                end
        end

endmodule : rr_arbiter

// File: logic/shared_mem_port.sv
// Single-port scratch memory
`timescale 1ns/1ps

module shared_mem_port (
        input  logic                            axi_aclk,
        input  logic                            axi_aresetn,
        // Granted request
        input  logic                            i_req_strobe,
        input  logic [mem_pkg::CH_W-1:0]        i_req_ch,
        input  logic [mem_pkg::REQ_W-1:0]       i_req_word,
        // Read response
        output logic                            o_rsp_valid,
        output logic [mem_pkg::CH_W-1:0]        o_rsp_ch,
        output logic [mem_pkg::MEM_DATA_W-1:0]  o_rsp_data
);

        localparam int AW = mem_pkg::MEM_ADDR_W;
        localparam int DW = mem_pkg::MEM_DATA_W;
        localparam int RW = mem_pkg::REQ_W;

        // -------------------------------------------------------------------------
        // Request decode
        // -------------------------------------------------------------------------
        mem_pkg::req_op_t w_op;
        logic [AW-1:0]    w_addr;
        logic [DW-1:0]    w_wdata;
        logic             w_do_write;
        logic             w_do_read;

        assign w_op    = mem_pkg::req_op_t'(i_req_word[RW-1]);
        assign w_addr  = i_req_word[DW +: AW];
        assign w_wdata = i_req_word[DW-1:0];

        assign w_do_write = i_req_strobe && (w_op == mem_pkg::op_write);
        assign w_do_read  = i_req_strobe && (w_op == mem_pkg::op_read);

        // -------------------------------------------------------------------------
        // Storage
        // -------------------------------------------------------------------------
        logic [DW-1:0] r_mem [mem_pkg::MEM_DEPTH];

        // Write lands at the end of the grant cycle
        always_ff @(posedge axi_aclk) begin
                if (w_do_write) begin
                        r_mem[w_addr] <= w_wdata;
                end
        end

        // One-cycle response pulse after a read grant
        always_ff @(posedge axi_aclk) begin
                if (!axi_aresetn) begin
                        o_rsp_valid <= 1'b0;
                        o_rsp_ch    <= '0;
                        o_rsp_data  <= '0;
                end else begin
                        o_rsp_valid <= w_do_read;
                        // Data and tag hold between reads
                        if (w_do_read) begin
                                o_rsp_ch   <= i_req_ch;
                                o_rsp_data <= r_mem[w_addr];
                        end
                end
        end

endmodule : shared_mem_port

// File: logic/req_mux_top.sv
// Two-channel request buffer top level
`timescale 1ns/1ps

module req_mux_top (
        input  logic                            axi_aclk,
        input  logic                            axi_aresetn,
        // Channel 0 push side
        input  logic                            i_ch0_wr_valid,
        output logic                            o_ch0_wr_ready,
        input  mem_pkg::req_op_t                i_ch0_wr_op,
        input  logic [mem_pkg::MEM_ADDR_W-1:0]  i_ch0_wr_addr,
        input  logic [mem_pkg::MEM_DATA_W-1:0]  i_ch0_wr_data,
        output logic [fifo_pkg::FIFO_CNT_W-1:0] o_ch0_count,
        // Channel 1 push side
        input  logic                            i_ch1_wr_valid,
        output logic                            o_ch1_wr_ready,
        input  mem_pkg::req_op_t                i_ch1_wr_op,
        input  logic [mem_pkg::MEM_ADDR_W-1:0]  i_ch1_wr_addr,
        input  logic [mem_pkg::MEM_DATA_W-1:0]  i_ch1_wr_data,
        output logic [fifo_pkg::FIFO_CNT_W-1:0] o_ch1_count,
        // Read responses
        output logic                            o_rsp_valid,
        output logic [mem_pkg::CH_W-1:0]        o_rsp_ch,
        output logic [mem_pkg::MEM_DATA_W-1:0]  o_rsp_data
);

        localparam int RW = mem_pkg::REQ_W;

        // -------------------------------------------------------------------------
        // Local signals
        // -------------------------------------------------------------------------
        logic [RW-1:0]              w_ch0_word;
        logic [RW-1:0]              w_ch1_word;
        logic [RW-1:0]              w_head [mem_pkg::N_CH];
        logic [mem_pkg::N_CH-1:0]   w_rd_valid;
        logic [mem_pkg::N_CH-1:0]   w_grant;
        logic                       w_req_strobe;
        logic [mem_pkg::CH_W-1:0]   w_grant_ch;
        logic [RW-1:0]              w_req_word;

        // Entry layout is op, addr, data
        assign w_ch0_word = {i_ch0_wr_op, i_ch0_wr_addr, i_ch0_wr_data};
        assign w_ch1_word = {i_ch1_wr_op, i_ch1_wr_addr, i_ch1_wr_data};

        // -------------------------------------------------------------------------
        // Channel FIFOs
        // -------------------------------------------------------------------------

        // Grant doubles as pop
        gaxi_fifo_sync #(
                .DATA_WIDTH (fifo_pkg::FIFO_DATA_W),
                .DEPTH      (fifo_pkg::FIFO_DEPTH)
        ) u_fifo_ch0 (
                .axi_aclk    (axi_aclk),
                .axi_aresetn (axi_aresetn),
                .i_wr_valid  (i_ch0_wr_valid),
                .o_wr_ready  (o_ch0_wr_ready),
                .i_wr_data   (w_ch0_word),
                .i_rd_ready  (w_grant[0]),
                .o_rd_valid  (w_rd_valid[0]),
                .o_rd_data   (w_head[0]),
                .o_count     (o_ch0_count)
        );

        gaxi_fifo_sync #(
                .DATA_WIDTH (fifo_pkg::FIFO_DATA_W),
                .DEPTH      (fifo_pkg::FIFO_DEPTH)
        ) u_fifo_ch1 (
                .axi_aclk    (axi_aclk),
                .axi_aresetn (axi_aresetn),
                .i_wr_valid  (i_ch1_wr_valid),
                .o_wr_ready  (o_ch1_wr_ready),
                .i_wr_data   (w_ch1_word),
                .i_rd_ready  (w_grant[1]),
                .o_rd_valid  (w_rd_valid[1]),
                .o_rd_data   (w_head[1]),
                .o_count     (o_ch1_count)
        );

        // -------------------------------------------------------------------------
        // Arbitration and memory
        // -------------------------------------------------------------------------
        rr_arbiter u_rr_arbiter (
                .axi_aclk     (axi_aclk),
                .axi_aresetn  (axi_aresetn),
                .i_valid      (w_rd_valid),
                .o_grant      (w_grant),
                .o_req_strobe (w_req_strobe),
                .o_grant_ch   (w_grant_ch)
        );

        // Head of the winning FIFO
        assign w_req_word = w_head[w_grant_ch];

        shared_mem_port u_shared_mem_port (
                .axi_aclk     (axi_aclk),
                .axi_aresetn  (axi_aresetn),
                .i_req_strobe (w_req_strobe),
                .i_req_ch     (w_grant_ch),
                .i_req_word   (w_req_word),
                .o_rsp_valid  (o_rsp_valid),
                .o_rsp_ch     (o_rsp_ch),
                .o_rsp_data   (o_rsp_data)
        );

endmodule : req_mux_top

// File: sim/mem_properties.sv
// Request buffer assertions
`timescale 1ns/1ps

module mem_properties (
        input  logic                            axi_aclk,
        input  logic                            axi_aresetn,
        input  logic [mem_pkg::N_CH-1:0]        i_grant,
        input  logic [mem_pkg::N_CH-1:0]        i_rd_valid,
        input  logic                            i_req_strobe,
        input  logic                            i_rsp_valid,
        input  logic [fifo_pkg::FIFO_CNT_W-1:0] i_ch0_count,
        input  logic [fifo_pkg::FIFO_CNT_W-1:0] i_ch1_count
);

        // Pop only from a FIFO that holds data
        a_grant_has_data : assert property (@(posedge axi_aclk) disable iff (!axi_aresetn)
                (i_grant & ~i_rd_valid) == '0)
                else $error("grant reached an empty FIFO");

        // Occupancy bounded by depth
        a_ch0_count : assert property (@(posedge axi_aclk) disable iff (!axi_aresetn)
                int'(i_ch0_count) <= fifo_pkg::FIFO_DEPTH)
                else $error("channel 0 count above depth");
        a_ch1_count : assert property (@(posedge axi_aclk) disable iff (!axi_aresetn)
                int'(i_ch1_count) <= fifo_pkg::FIFO_DEPTH)
                else $error("channel 1 count above depth");

        // Back-to-back responses need back-to-back strobes
        a_rsp_spacing : assert property (@(posedge axi_aclk) disable iff (!axi_aresetn)
                (i_rsp_valid && $past(i_rsp_valid)) |->
                ($past(i_req_strobe) && $past(i_req_strobe, 2)))
                else $error("response pulse without a matching strobe");

        // One winner at most
        a_grant_onehot : assert property (@(posedge axi_aclk) disable iff (!axi_aresetn)
                $onehot0(i_grant))
                else $error("both channels granted together");

endmodule : mem_properties

bind req_mux_top mem_properties u_mem_properties (
        .axi_aclk     (axi_aclk),
        .axi_aresetn  (axi_aresetn),
        .i_grant      (w_grant),
        .i_rd_valid   (w_rd_valid),
        .i_req_strobe (w_req_strobe),
        .i_rsp_valid  (o_rsp_valid),
        .i_ch0_count  (o_ch0_count),
        .i_ch1_count  (o_ch1_count)
);

// File: sim/tb_top.sv
// Request buffer testbench
`timescale 1ns/1ps

module tb_top;

        localparam int AW = mem_pkg::MEM_ADDR_W;
        localparam int DW = mem_pkg::MEM_DATA_W;
        localparam int N_ROWS = 8;
        // Random requests per channel
        localparam int RND_N = 24;
        localparam int WATCHDOG_CYCLES = 20 * N_ROWS + 20 * 2 * RND_N;

        typedef struct packed {
                logic             ch;
                mem_pkg::req_op_t op;
                logic [AW-1:0]    addr;
                logic [DW-1:0]    data;
                logic [DW-1:0]    exp;
        } row_t;

        // Writes then read-backs, channel 0 then channel 1
        localparam row_t STIM [N_ROWS] = '{
                '{1'b0, mem_pkg::op_write, 4'h2, 8'ha5, 8'h00},
                '{1'b0, mem_pkg::op_write, 4'h3, 8'h3c, 8'h00},
                '{1'b0, mem_pkg::op_read,  4'h2, 8'h00, 8'ha5},
                '{1'b0, mem_pkg::op_read,  4'h3, 8'h00, 8'h3c},
                '{1'b1, mem_pkg::op_write, 4'h9, 8'hc3, 8'h00},
                '{1'b1, mem_pkg::op_write, 4'ha, 8'h7e, 8'h00},
                '{1'b1, mem_pkg::op_read,  4'h9, 8'h00, 8'hc3},
                '{1'b1, mem_pkg::op_read,  4'ha, 8'h00, 8'h7e}
        };

        // -------------------------------------------------------------------------
        // DUT signals, indexed by channel
        // -------------------------------------------------------------------------
        logic                            axi_aclk;
        logic                            axi_aresetn;
        logic                            wr_valid [2];
        logic                            wr_ready [2];
        mem_pkg::req_op_t                wr_op [2];
        logic [AW-1:0]                   wr_addr [2];
        logic [DW-1:0]                   wr_data [2];
        logic [fifo_pkg::FIFO_CNT_W-1:0] wr_count [2];
        logic                            rsp_valid;
        logic [mem_pkg::CH_W-1:0]        rsp_ch;
        logic [DW-1:0]                   rsp_data;

        // Reference model and bookkeeping
        logic [DW-1:0]    ref_mem [mem_pkg::MEM_DEPTH];
        logic [DW-1:0]    exp_q [2][$];
        int               rsp_log [$];
        int               reads_pushed;
        int               rsp_count;
        logic             saw_full;
        logic [31:0]      rnd_state;
        mem_pkg::req_op_t rnd_op [2][RND_N];
        logic [AW-1:0]    rnd_addr [2][RND_N];
        logic [DW-1:0]    rnd_data [2][RND_N];

        req_mux_top i_dut (
                .axi_aclk       (axi_aclk),
                .axi_aresetn    (axi_aresetn),
                .i_ch0_wr_valid (wr_valid[0]),
                .o_ch0_wr_ready (wr_ready[0]),
                .i_ch0_wr_op    (wr_op[0]),
                .i_ch0_wr_addr  (wr_addr[0]),
                .i_ch0_wr_data  (wr_data[0]),
                .o_ch0_count    (wr_count[0]),
                .i_ch1_wr_valid (wr_valid[1]),
                .o_ch1_wr_ready (wr_ready[1]),
                .i_ch1_wr_op    (wr_op[1]),
                .i_ch1_wr_addr  (wr_addr[1]),
                .i_ch1_wr_data  (wr_data[1]),
                .o_ch1_count    (wr_count[1]),
                .o_rsp_valid    (rsp_valid),
                .o_rsp_ch       (rsp_ch),
                .o_rsp_data     (rsp_data)
        );

        // 100 ns period
        always #50 axi_aclk = ~axi_aclk;

        // -------------------------------------------------------------------------
        // Helpers
        // -------------------------------------------------------------------------
        task automatic abort_run(input string why);
                $display("%s", why);
                $display("SIMULATION FAILED");
                $fatal(1, "run stopped");
        endtask

        task automatic check_value(input string name, input logic [31:0] actual,
                                   input logic [31:0] expected);
                if (actual !== expected) begin
                        abort_run($sformatf("mismatch at %0t ns: %s is %0h, expected %0h",
                                            $time, name, actual, expected));
                end
        endtask

        // Xorshift32 step
        function automatic logic [31:0] next_random(input logic [31:0] x);
                logic [31:0] y;
                y = x ^ (x << 13);
                y = y ^ (y >> 17);
                y = y ^ (y << 5);
                return y;
        endfunction

        // Initial memory image, spread over every address bit
        function automatic logic [DW-1:0] fill_byte(input logic [AW-1:0] a);
                logic [DW-1:0] v;
                v = DW'(a) * DW'(37);
                return v ^ DW'(8'h5c);
        endfunction

        // Push one request, model updated at acceptance
        task automatic push_req(input int ch, input mem_pkg::req_op_t op,
                                input logic [AW-1:0] addr, input logic [DW-1:0] data,
                                input logic [DW-1:0] exp);
                wr_valid[ch] = 1'b1;
                wr_op[ch]    = op;
                wr_addr[ch]  = addr;
                wr_data[ch]  = data;
                while (!wr_ready[ch]) @(negedge axi_aclk);
                if (op == mem_pkg::op_write) begin
                        ref_mem[addr] = data;
                end else begin
                        exp_q[ch].push_back(exp);
                        reads_pushed++;
                end
                @(negedge axi_aclk);
                wr_valid[ch] = 1'b0;
        endtask

        // Back-to-back pushes from one channel
        task automatic run_random(input int ch);
                for (int i = 0; i < RND_N; i++) begin
                        push_req(ch, rnd_op[ch][i], rnd_addr[ch][i], rnd_data[ch][i],
                                 ref_mem[rnd_addr[ch][i]]);
                end
        endtask

        // Until both FIFOs are empty, then one cycle for the last response
        task automatic wait_drain();
                while (wr_count[0] != '0 || wr_count[1] != '0) @(negedge axi_aclk);
                @(negedge axi_aclk);
        endtask

        // -------------------------------------------------------------------------
        // Response monitor, sampled mid-cycle
        // -------------------------------------------------------------------------
        always @(negedge axi_aclk) begin
                if (axi_aresetn) begin
                        if (!wr_ready[0] || !wr_ready[1]) saw_full = 1'b1;
                        if (int'(wr_count[0]) > fifo_pkg::FIFO_DEPTH ||
                            int'(wr_count[1]) > fifo_pkg::FIFO_DEPTH) begin
                                abort_run("a channel count went above the FIFO depth");
                        end
                        if (rsp_valid) begin
                                if (exp_q[rsp_ch].size() == 0) begin
                                        abort_run(
                                                "read response on a channel with no read pending");
                                end
                                check_value("o_rsp_data", 32'(rsp_data),
                                            32'(exp_q[rsp_ch].pop_front()));
                                rsp_log.push_back(int'(rsp_ch));
                                rsp_count++;
                        end
                end
        end

        initial begin : watchdog
                repeat (WATCHDOG_CYCLES) @(posedge axi_aclk);
                abort_run("timeout, the run did not finish within its cycle budget");
        end

        // -------------------------------------------------------------------------
        // Main sequence
        // -------------------------------------------------------------------------
        initial begin : stimulus
                int base;
                axi_aclk     = 1'b0;
                axi_aresetn  = 1'b0;
                reads_pushed = 0;
                rsp_count    = 0;
                saw_full     = 1'b0;
                rnd_state    = 32'd26;
                for (int c = 0; c < 2; c++) begin
                        wr_valid[c] = 1'b0;
                        wr_op[c]    = mem_pkg::op_write;
                        wr_addr[c]  = '0;
                        wr_data[c]  = '0;
                end
                repeat (4) @(posedge axi_aclk);
                @(negedge axi_aclk);
                axi_aresetn = 1'b1;

                // Idle state out of reset
                check_value("o_rsp_valid", 32'(rsp_valid), 32'd0);
                check_value("o_ch0_wr_ready", 32'(wr_ready[0]), 32'd1);
                check_value("o_ch1_wr_ready", 32'(wr_ready[1]), 32'd1);
                check_value("o_ch0_count", 32'(wr_count[0]), 32'd0);
                check_value("o_ch1_count", 32'(wr_count[1]), 32'd0);

                // Known image, low half via ch0, high half via ch1
                for (int i = 0; i < mem_pkg::MEM_DEPTH; i++) begin
                        push_req(i / 8, mem_pkg::op_write, AW'(i), fill_byte(AW'(i)), '0);
                end
                wait_drain();

                // Table rows, one push at a time
                for (int r = 0; r < N_ROWS; r++) begin
                        push_req(int'(STIM[r].ch), STIM[r].op, STIM[r].addr, STIM[r].data,
                                 STIM[r].exp);
                end
                wait_drain();

                // First tie, ch0 wins then grants alternate
                base = rsp_log.size();
                fork
                        push_req(0, mem_pkg::op_read, 4'h2, '0, ref_mem[2]);
                        push_req(1, mem_pkg::op_read, 4'h9, '0, ref_mem[9]);
                join
                fork
                        push_req(0, mem_pkg::op_read, 4'h3, '0, ref_mem[3]);
                        push_req(1, mem_pkg::op_read, 4'ha, '0, ref_mem[10]);
                join
                wait_drain();
                for (int i = 0; i < 4; i++) begin
                        check_value("o_rsp_ch", 32'(rsp_log[base + i]), 32'(i % 2));
                end

                // Random traffic, each channel in its own half
                for (int c = 0; c < 2; c++) begin
                        for (int i = 0; i < RND_N; i++) begin
                                rnd_state      = next_random(rnd_state);
                                rnd_op[c][i]   = mem_pkg::req_op_t'(rnd_state[0]);
                                rnd_addr[c][i] = {c[0], rnd_state[AW-1:1]};
                                rnd_data[c][i] = DW'(rnd_state >> 8);
                        end
                end
                saw_full = 1'b0;
                fork
                        run_random(0);
                        run_random(1);
                join
                wait_drain();
                check_value("wr_ready low seen", 32'(saw_full), 32'd1);

                // Full read-back of the model image
                for (int i = 0; i < mem_pkg::MEM_DEPTH; i++) begin
                        push_req(i / 8, mem_pkg::op_read, AW'(i), '0, ref_mem[i]);
                end
                wait_drain();
                check_value("response count", rsp_count, reads_pushed);

                $display("SIMULATION PASSED");
                $finish;
        end

endmodule : tb_top

// File: sources.f
logic/mem_pkg.sv
logic/fifo_pkg.sv
logic/fifo_control.sv
logic/gaxi_fifo_sync.sv
logic/rr_arbiter.sv
logic/shared_mem_port.sv
logic/req_mux_top.sv
sim/mem_properties.sv
sim/tb_top.sv

// File: run.sh
#!/bin/sh
# Build and run the request buffer simulation with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
        --top-module tb_top \
        --Mdir obj_dir \
        -o tb_top \
        -f sources.f
status=$?
if [ "$status" -ne 0 ]; then
        echo "Verilator build failed with status $status"
        exit "$status"
fi

./obj_dir/tb_top
status=$?
if [ "$status" -ne 0 ]; then
        echo "Simulation ended with status $status"
        exit "$status"
fi

exit 0
